// File: hdl/icache_axi_top.sv
`timescale 1ns/100ps

module icache_axi_top (
  input  logic                    clk,
  input  logic                    rst_n,

  // Requester
  input  logic                    i_ren,
  input  icache_pkg::cache_req_t  i_req,
  output logic                    o_rsp_valid,
  output icache_pkg::cache_rsp_t  o_rsp,

  // AXI read
  output logic                    o_arvalid,
  output icache_pkg::axi_ar_t     o_ar,
  input  logic                    i_arready,
  input  logic                    i_rvalid,
  input  icache_pkg::axi_r_t      i_r
);
  import icache_pkg::*;

  // ========================================
  // Internal wiring
  // ========================================
  logic [SET_W-1:0]      lookup_set;
  logic [TAG_W-1:0]      lookup_tag;
  logic                  hit;
  logic                  hit_way;
  logic                  victim_way;
  logic                  touch;
  logic                  fill_done;
  fill_tgt_t             fill;
  logic                  beat_we;
  logic [WORD_IDX_W-1:0] beat_base;
  logic                  rd_en;
  logic [SET_W-1:0]      rd_set;
  logic                  rd_way;
  logic [WORD_IDX_W-1:0] rd_word;

  icache_refill refill0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ren       (i_ren),
    .i_req       (i_req),
    .o_lookup_set(lookup_set),
    .o_lookup_tag(lookup_tag),
    .i_hit       (hit),
    .i_hit_way   (hit_way),
    .i_victim_way(victim_way),
    .o_touch     (touch),
    .o_fill_done (fill_done),
    .o_fill      (fill),
    .o_beat_we   (beat_we),
    .o_beat_base (beat_base),
    .o_rd_en     (rd_en),
    .o_rd_set    (rd_set),
    .o_rd_way    (rd_way),
    .o_rd_word   (rd_word),
    .o_arvalid   (o_arvalid),
    .o_ar        (o_ar),
    .i_arready   (i_arready),
    .i_rvalid    (i_rvalid),
    .i_r         (i_r),
    .o_rsp_valid (o_rsp_valid)
  );

  icache_tag_store tags0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_set       (lookup_set),
    .i_tag       (lookup_tag),
    .o_hit       (hit),
    .o_hit_way   (hit_way),
    .o_victim_way(victim_way),
    .i_touch     (touch),
    .i_fill_done (fill_done),
    .i_fill      (fill)
  );

  icache_data_store data0 (
    .clk        (clk),
    .i_beat_we  (beat_we),
    .i_fill     (fill),
    .i_beat_base(beat_base),
    .i_beat_data(i_r.data),
    .i_rd_en    (rd_en),
    .i_rd_set   (rd_set),
    .i_rd_way   (rd_way),
    .i_rd_word  (rd_word),
    .o_rd_data  (o_rsp)
  );

endmodule

// File: hdl/icache_data_store.sv
`timescale 1ns/100ps

module icache_data_store (
  input  logic                                 clk,

  // Fill side, one AXI beat per write
  input  logic                                 i_beat_we,
  input  icache_pkg::fill_tgt_t                i_fill,
  input  logic [icache_pkg::WORD_IDX_W-1:0]    i_beat_base,
  input  logic [icache_pkg::AXI_DATA_W-1:0]    i_beat_data,

  // Read side, one word per cycle
  input  logic                                 i_rd_en,
  input  logic [icache_pkg::SET_W-1:0]         i_rd_set,
  input  logic                                 i_rd_way,
  input  logic [icache_pkg::WORD_IDX_W-1:0]    i_rd_word,
  output icache_pkg::cache_rsp_t               o_rd_data
);
  import icache_pkg::*;

  logic [31:0]           mem_q [NUM_SETS][NUM_WAYS][WORDS_PER_LINE];

  logic [WORD_IDX_W-1:0] beat_off;
  logic                  fwd_hit;
  logic [31:0]           fwd_word;

  // ========================================
  // Beat write
  // ========================================
  always_ff @(posedge clk) begin
    if (i_beat_we) begin
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        mem_q[i_fill.set][i_fill.way][i_beat_base + WORD_IDX_W'(i)] <=
          i_beat_data[i*32 +: 32];
      end
    end
  end

  // ========================================
  // Word read with write bypass
  // ========================================
  // Position of the read word inside the beat now being written
  assign beat_off = i_rd_word - i_beat_base;

  always_comb begin
    fwd_word = '0;
    for (int i = 0; i < WORDS_PER_BEAT; i++) begin
      if (beat_off == WORD_IDX_W'(i)) begin
        fwd_word = i_beat_data[i*32 +: 32];
      end
    end
  end

  assign fwd_hit = i_beat_we && (i_fill.set == i_rd_set) && (i_fill.way == i_rd_way) &&
                   (int'(beat_off) < WORDS_PER_BEAT);

  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data.data <= fwd_hit ? fwd_word : mem_q[i_rd_set][i_rd_way][i_rd_word];
    end
  end

endmodule

// File: hdl/icache_pkg.sv
package icache_pkg;

  // ========================================
  // Cache geometry
  // ========================================
  localparam int LINE_BYTES     = 32;
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 64;
  localparam int WORDS_PER_LINE = LINE_BYTES / 4;

  // Address split is tag | set | word | byte
  localparam int OFFSET_W   = $clog2(LINE_BYTES);
  localparam int SET_W      = $clog2(NUM_SETS);
  localparam int TAG_W      = 32 - SET_W - OFFSET_W;
  localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);

  // ========================================
  // AXI read port
  // ========================================
  localparam int AXI_DATA_W     = 128;
  localparam int WORDS_PER_BEAT = AXI_DATA_W / 32;
  localparam int BEATS_PER_LINE = WORDS_PER_LINE / WORDS_PER_BEAT;
  localparam int AXI_ID_W       = 4;

  // One burst covers a whole line
  localparam logic [7:0] AXI_ARLEN      = 8'(BEATS_PER_LINE - 1);
  localparam logic [2:0] AXI_ARSIZE     = 3'($clog2(AXI_DATA_W / 8));
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic {
    REFILL_IDLE,
    REFILL_BURST
  } refill_state_e;

  // Requester byte address, split into its cache fields
  typedef struct packed {
    logic [TAG_W-1:0]               tag;
    logic [SET_W-1:0]               set;
    logic [WORD_IDX_W-1:0]          word;
    logic [OFFSET_W-WORD_IDX_W-1:0] byte_off;
  } cache_req_t;

  typedef struct packed {
    logic [31:0] data;
  } cache_rsp_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [31:0]         addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  // Line being filled and the word the requester asked for
  typedef struct packed {
    logic [SET_W-1:0]      set;
    logic                  way;
    logic [TAG_W-1:0]      tag;
    logic [WORD_IDX_W-1:0] word;
  } fill_tgt_t;

endpackage

// File: hdl/icache_refill.sv
`timescale 1ns/100ps

module icache_refill (
  input  logic                              clk,
  input  logic                              rst_n,

  // Requester
  input  logic                              i_ren,
  input  icache_pkg::cache_req_t            i_req,

  // Tag store
  output logic [icache_pkg::SET_W-1:0]      o_lookup_set,
  output logic [icache_pkg::TAG_W-1:0]      o_lookup_tag,
  input  logic                              i_hit,
  input  logic                              i_hit_way,
  input  logic                              i_victim_way,
  output logic                              o_touch,
  output logic                              o_fill_done,
  output icache_pkg::fill_tgt_t             o_fill,

  // Data store
  output logic                              o_beat_we,
  output logic [icache_pkg::WORD_IDX_W-1:0] o_beat_base,
  output logic                              o_rd_en,
  output logic [icache_pkg::SET_W-1:0]      o_rd_set,
  output logic                              o_rd_way,
  output logic [icache_pkg::WORD_IDX_W-1:0] o_rd_word,

  // AXI read
  output logic                              o_arvalid,
  output icache_pkg::axi_ar_t               o_ar,
  input  logic                              i_arready,
  input  logic                              i_rvalid,
  input  icache_pkg::axi_r_t                i_r,

  output logic                              o_rsp_valid
);
  import icache_pkg::*;

  refill_state_e         state_q;
  logic                  arvalid_q;
  axi_ar_t               ar_q;
  fill_tgt_t             fill_q;
  logic [WORD_IDX_W-1:0] beat_base_q;
  logic                  rsp_valid_q;

  logic                  hit_access;
  logic                  miss_start;
  logic                  beat_we;
  logic                  fill_done;

  // ========================================
  // Access decode
  // ========================================
  assign o_lookup_set = i_req.set;
  assign o_lookup_tag = i_req.tag;

  // Requests during a burst break the protocol and are dropped
  assign hit_access = (state_q == REFILL_IDLE) && i_ren && i_hit;
  assign miss_start = (state_q == REFILL_IDLE) && i_ren && !i_hit;

  // RREADY is always high, so every valid beat lands
  assign beat_we   = (state_q == REFILL_BURST) && i_rvalid;
  assign fill_done = beat_we && i_r.last;

  assign o_touch     = hit_access;
  assign o_fill_done = fill_done;
  assign o_fill      = fill_q;
  assign o_beat_we   = beat_we;
  assign o_beat_base = beat_base_q;

  // Fill-done reads the requested word, bypassing the last beat if needed
  assign o_rd_en   = hit_access || fill_done;
  assign o_rd_set  = fill_done ? fill_q.set  : i_req.set;
  assign o_rd_way  = fill_done ? fill_q.way  : i_hit_way;
  assign o_rd_word = fill_done ? fill_q.word : i_req.word;

  // ========================================
  // Miss FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= REFILL_IDLE;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        REFILL_IDLE: begin
          if (miss_start) begin
            state_q   <= REFILL_BURST;
            arvalid_q <= 1'b1;
          end
        end
        REFILL_BURST: begin
          // Hold AR until accepted
          if (arvalid_q && i_arready) begin
            arvalid_q <= 1'b0;
          end
          if (fill_done) begin
            state_q <= REFILL_IDLE;
          end
        end
        default: begin
          state_q <= REFILL_IDLE;
        end
      endcase
    end
  end

  // AR payload and fill target, captured once per miss
  always_ff @(posedge clk) begin
    if (miss_start) begin
      ar_q.id    <= '0;
      ar_q.addr  <= {i_req.tag, i_req.set, {OFFSET_W{1'b0}}};
      ar_q.len   <= AXI_ARLEN;
      ar_q.size  <= AXI_ARSIZE;
      ar_q.burst <= AXI_BURST_INCR;
      fill_q.set  <= i_req.set;
      fill_q.way  <= i_victim_way;
      fill_q.tag  <= i_req.tag;
      fill_q.word <= i_req.word;
    end
  end

  // Beat counter, in words
  always_ff @(posedge clk) begin
    if (miss_start) begin
      beat_base_q <= '0;
    end else if (beat_we) begin
      beat_base_q <= beat_base_q + WORD_IDX_W'(WORDS_PER_BEAT);
    end
  end

  // Response one cycle after a hit or fill-done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= hit_access || fill_done;
    end
  end

  assign o_arvalid   = arvalid_q;
  assign o_ar        = ar_q;
  assign o_rsp_valid = rsp_valid_q;

endmodule

// File: hdl/icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store (
  input  logic                                clk,
  input  logic                                rst_n,

  // Lookup
  input  logic [icache_pkg::SET_W-1:0]        i_set,
  input  logic [icache_pkg::TAG_W-1:0]        i_tag,
  output logic                                o_hit,
  output logic                                o_hit_way,
  output logic                                o_victim_way,

  // Update
  input  logic                                i_touch,
  input  logic                                i_fill_done,
  input  icache_pkg::fill_tgt_t               i_fill
);
  import icache_pkg::*;

  // ========================================
  // Storage
  // ========================================
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];

  // Way to evict next in each set
  logic                lru_q   [NUM_SETS];

  logic [NUM_WAYS-1:0] set_valid;
  logic [NUM_WAYS-1:0] way_hit;

  // ========================================
  // Lookup
  // ========================================
  assign set_valid = valid_q[i_set];

  // Both ways compared in parallel
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = set_valid[w] && (tag_q[i_set][w] == i_tag);
    end
  end

  assign o_hit = |way_hit;

  always_comb begin
    o_hit_way = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        o_hit_way = w[0];
      end
    end
  end

  // Invalid way first, then LRU
  always_comb begin
    if (!set_valid[0]) begin
      o_victim_way = 1'b0;
    end else if (!set_valid[1]) begin
      o_victim_way = 1'b1;
    end else begin
      o_victim_way = lru_q[i_set];
    end
  end

  // ========================================
  // Update
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (i_fill_done) begin
      valid_q[i_fill.set][i_fill.way] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fill_done) begin
      tag_q[i_fill.set][i_fill.way] <= i_fill.tag;
    end
  end

  // Accessed way becomes MRU, so the other one is next to go
  always_ff @(posedge clk) begin
    if (i_touch) begin
      lru_q[i_set] <= ~o_hit_way;
    end else if (i_fill_done) begin
      lru_q[i_fill.set] <= ~i_fill.way;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module icache_tb \
  --Mdir "$BUILD_DIR" \
  -o icache_sim

"$BUILD_DIR/icache_sim" +verilator+error+limit+1000 | tee "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

// File: tb/icache_checker.sv
`timescale 1ns/100ps

module icache_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_arvalid,
  input  logic                 i_arready,
  input  icache_pkg::axi_ar_t  i_ar,
  input  logic                 i_rsp_valid
);
  import icache_pkg::*;

  // AR held steady under back-pressure
  ar_held: assert property (@(posedge clk) disable iff (!rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_ar))
    else $error("AR request dropped or changed while ARREADY was low");

  // Burst always starts on a line boundary
  ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    i_arvalid |-> i_ar.addr[OFFSET_W-1:0] == '0)
    else $error("AR address is not line aligned");

  rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
    i_rsp_valid |=> !i_rsp_valid)
    else $error("Response strobe stayed high for two cycles");

endmodule

bind icache_refill icache_checker checker0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .i_arvalid  (o_arvalid),
  .i_arready  (i_arready),
  .i_ar       (o_ar),
  .i_rsp_valid(o_rsp_valid)
);

// File: tb/icache_monitor.sv
`timescale 1ns/100ps

module icache_monitor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ren,
  input  icache_pkg::cache_req_t  i_req,
  input  logic                    i_rsp_valid,
  input  icache_pkg::cache_rsp_t  i_rsp,
  input  logic                    i_arvalid,
  input  icache_pkg::axi_ar_t     i_ar,
  input  logic                    i_arready,
  input  logic                    i_rvalid,
  input  icache_pkg::axi_r_t      i_r,
  output int                      o_checks,
  output int                      o_errors
);
  import icache_pkg::*;

  // ========================================
  // Reference model
  // ========================================
  logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
  logic [TAG_W-1:0]    m_tag   [NUM_SETS][NUM_WAYS];
  logic                m_lru   [NUM_SETS];

  int          cycle;
  int          rsp_due;
  int          ar_due;
  logic        miss_pending;
  logic        ar_taken;
  logic        stalled;
  axi_ar_t     prev_ar;
  logic [31:0] exp_data;
  logic [31:0] exp_addr;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    o_checks++;
    if (exp !== act) begin
      o_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report(input string what);
    o_errors++;
    $display("Error at cycle %0d: %s", cycle, what);
  endtask

  // Invalid way first, then LRU, model updated when the request is seen
  task automatic predict(input cache_req_t q);
    logic hit;
    logic hit_way;
    logic victim;
    hit = 1'b0;
    hit_way = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[q.set][w] && m_tag[q.set][w] == q.tag) begin
        hit = 1'b1;
        hit_way = w[0];
      end
    end
    exp_data = {2'b00, q[31:2]} ^ 32'hc0de0000;
    if (hit) begin
      m_lru[q.set] = ~hit_way;
      rsp_due = cycle + 1;
    end else begin
      victim = !m_valid[q.set][0] ? 1'b0 : (!m_valid[q.set][1] ? 1'b1 : m_lru[q.set]);
      m_valid[q.set][victim] = 1'b1;
      m_tag[q.set][victim] = q.tag;
      m_lru[q.set] = ~victim;
      exp_addr = {q[31:OFFSET_W], {OFFSET_W{1'b0}}};
      miss_pending = 1'b1;
      ar_taken = 1'b0;
      ar_due = cycle + 1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        m_valid[s] = '0;
        m_lru[s] = 1'b0;
      end
      cycle = 0;
      rsp_due = -1;
      ar_due = -1;
      miss_pending = 1'b0;
      ar_taken = 1'b0;
      stalled = 1'b0;
      o_checks = 0;
      o_errors = 0;
    end else begin
      cycle++;
      if (i_rsp_valid && cycle != rsp_due) begin
        report("response strobe without a pending request");
      end else if (i_rsp_valid) begin
        check("read_data", exp_data, i_rsp.data);
      end else if (cycle == rsp_due) begin
        report("expected response did not arrive on time");
      end
      if (cycle == ar_due && !i_arvalid) begin
        report("no AR request one cycle after a predicted miss");
      end
      if (stalled && (!i_arvalid || i_ar !== prev_ar)) begin
        report("AR request dropped or changed while stalled");
      end
      if (i_arvalid) begin
        if (!miss_pending || ar_taken) begin
          report("AR request without a predicted miss");
        end else begin
          check("ar_addr", exp_addr, i_ar.addr);
          check("ar_len", 32'd1, 32'(i_ar.len));
          check("ar_size", 32'd4, 32'(i_ar.size));
          check("ar_burst", 32'd1, 32'(i_ar.burst));
        end
        if (i_arready) begin
          ar_taken = 1'b1;
        end
      end
      stalled = i_arvalid && !i_arready;
      prev_ar = i_ar;
      // Response is due one cycle after the last beat
      if (miss_pending && i_rvalid && i_r.last) begin
        rsp_due = cycle + 1;
        miss_pending = 1'b0;
      end
      if (i_ren) begin
        predict(i_req);
      end
    end
  end

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  localparam int NUM_REQS    = 400;
  localparam int RSP_TIMEOUT = 200;

  localparam logic [TAG_W-1:0] TAG_BASE = 21'h0d2c0;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        ren;
  cache_req_t  req;
  logic        rsp_valid;
  cache_rsp_t  rsp;
  logic        arvalid;
  axi_ar_t     ar;
  logic        arready;
  logic        rvalid;
  axi_r_t      rbus;
  logic [31:0] lfsr_q = 32'h49d9;
  int          checks;
  int          errors;
  int          timeouts = 0;

  always #5 clk = ~clk;

  icache_axi_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ren      (ren),
    .i_req      (req),
    .o_rsp_valid(rsp_valid),
    .o_rsp      (rsp),
    .o_arvalid  (arvalid),
    .o_ar       (ar),
    .i_arready  (arready),
    .i_rvalid   (rvalid),
    .i_r        (rbus)
  );

  icache_monitor mon0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ren      (ren),
    .i_req      (req),
    .i_rsp_valid(rsp_valid),
    .i_rsp      (rsp),
    .i_arvalid  (arvalid),
    .i_ar       (ar),
    .i_arready  (arready),
    .i_rvalid   (rvalid),
    .i_r        (rbus),
    .o_checks   (checks),
    .o_errors   (errors)
  );

  // ========================================
  // Stimulus helpers
  // ========================================
  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ 32'hc0de0000;
  endfunction

  // AXI slave side of one miss, with random stall gaps
  task automatic serve_miss();
    logic [31:0] r;
    logic [31:0] line_addr;
    axi_r_t      beat;
    line_addr = ar.addr;
    draw(2, r);
    for (int g = 0; g < int'(r[1:0]); g++) @(negedge clk);
    arready = 1'b1;
    @(negedge clk);
    arready = 1'b0;
    for (int b = 0; b < BEATS_PER_LINE; b++) begin
      draw(2, r);
      for (int g = 0; g < int'(r[1:0]); g++) @(negedge clk);
      beat = '0;
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        beat.data[i*32 +: 32] = mem_word(line_addr + 32'(b * 16 + i * 4));
      end
      beat.last = (b == BEATS_PER_LINE - 1);
      rbus = beat;
      rvalid = 1'b1;
      @(negedge clk);
      rvalid = 1'b0;
    end
  endtask

  // 4 tags over 4 sets so that both ways fill and get evicted
  task automatic do_request(input int n);
    logic [31:0] r;
    cache_req_t  q;
    int          waited;
    logic        done;
    draw(2, r);
    q.tag = TAG_BASE + TAG_W'(r[1:0]);
    draw(2, r);
    q.set = SET_W'(5) + SET_W'(r[1:0]) * SET_W'(17);
    draw(3, r);
    q.word = r[2:0];
    draw(2, r);
    q.byte_off = r[1:0];
    ren = 1'b1;
    req = q;
    @(negedge clk);
    ren = 1'b0;
    waited = 0;
    done = 1'b0;
    while (!done && timeouts == 0) begin
      if (rsp_valid) begin
        done = 1'b1;
      end else if (waited >= RSP_TIMEOUT) begin
        $display("Timeout: request %0d got no response in %0d cycles", n, RSP_TIMEOUT);
        timeouts++;
      end else if (arvalid) begin
        serve_miss();
        waited++;
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    // Response is taken at the next edge, the new strobe comes after it
    @(negedge clk);
    draw(1, r);
    if (r[0]) @(negedge clk);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    rst_n = 1'b0;
    ren = 1'b0;
    req = '0;
    arready = 1'b0;
    rvalid = 1'b0;
    rbus = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Idle cycles check that nothing answers unasked
    repeat (5) @(negedge clk);
    for (int n = 0; n < NUM_REQS && timeouts == 0; n++) begin
      do_request(n);
    end
    repeat (4) @(negedge clk);
    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_refill.sv
hdl/icache_axi_top.sv
tb/icache_checker.sv
tb/icache_monitor.sv
tb/icache_tb.sv
